// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    // csr address space is 14 bits wide
    typedef logic [13:0] csr_addr_t;

    localparam csr_addr_t CSR_CRMD    = 14'h0;
    localparam csr_addr_t CSR_PRMD    = 14'h1;
    localparam csr_addr_t CSR_ESTAT   = 14'h5;
    localparam csr_addr_t CSR_ERA     = 14'h6;
    localparam csr_addr_t CSR_BADV    = 14'h7;
    localparam csr_addr_t CSR_EENTRY  = 14'hc;
    localparam csr_addr_t CSR_TLBIDX  = 14'h10;
    localparam csr_addr_t CSR_TLBEHI  = 14'h11;
    localparam csr_addr_t CSR_TLBELO0 = 14'h12;
    localparam csr_addr_t CSR_TLBELO1 = 14'h13;
    localparam csr_addr_t CSR_ASID    = 14'h18;
    localparam csr_addr_t CSR_SAVE0   = 14'h30;
    localparam csr_addr_t CSR_SAVE1   = 14'h31;
    localparam csr_addr_t CSR_SAVE2   = 14'h32;
    localparam csr_addr_t CSR_SAVE3   = 14'h33;

    // tlb geometry
    localparam int TLB_NUM     = 4;
    localparam int TLB_IDX_WID = 2;
    localparam int ASID_WID    = 10;
    // vppn covers va[31:13]
    localparam int VPPN_WID    = 19;

    // crmd after reset: plv 0, ie 0, da 1
    localparam logic [8:0] CRMD_RESET = 9'h008;

    typedef enum logic [5:0] {
        ecode_int = 6'h0,
        ecode_pil = 6'h1,
        ecode_pis = 6'h2,
        ecode_pif = 6'h3,
        ecode_pme = 6'h4,
        ecode_ppi = 6'h7,
        ecode_ade = 6'h8,
        ecode_ale = 6'h9,
        ecode_sys = 6'hb,
        ecode_brk = 6'hc,
        ecode_ine = 6'hd
    } ecode_t;

    typedef enum logic [1:0] {
        tlb_none = 2'd0,
        tlb_srch = 2'd1,
        tlb_rd   = 2'd2,
        tlb_wr   = 2'd3
    } tlb_op_t;

endpackage

// ==== hdl/excp_unit.sv ====
module excp_unit (
    // exception request from the pipeline
    input  logic            excp_valid,
    input  csr_pkg::ecode_t excp_ecode,
    input  logic [31:0]     excp_pc,
    input  logic            excp_badv_valid,
    input  logic [31:0]     excp_badv,
    input  logic            ertn,

    // current register values
    input  logic [1:0]      crmd_plv,
    input  logic            crmd_ie,
    input  logic [31:0]     eentry,
    input  logic [31:0]     era,

    // write request toward the csr file
    output logic            excp_we,
    output logic [1:0]      new_prmd_pplv,
    output logic            new_prmd_pie,
    output csr_pkg::ecode_t new_ecode,
    output logic [31:0]     new_era,
    output logic            badv_we,
    output logic [31:0]     new_badv,

    // fetch redirect
    output logic            redirect_valid,
    output logic [31:0]     redirect_pc
);

    // entry saves the running plv and ie so that ertn can bring them back
    assign excp_we       = excp_valid;
    assign new_prmd_pplv = crmd_plv;
    assign new_prmd_pie  = crmd_ie;
    assign new_ecode     = excp_ecode;
    assign new_era       = excp_pc;

    // only address-related exceptions carry a bad virtual address
    assign badv_we  = excp_valid & excp_badv_valid;
    assign new_badv = excp_badv;

    assign redirect_valid = excp_valid | ertn;
    assign redirect_pc    = excp_valid ? eentry : era;

    // an ertn is itself retired, so it cannot raise an exception in the same slot
    always_comb begin
        assert final (!(excp_valid && ertn))
            else $error("excp_unit: exception and ertn in the same cycle");
    end

endmodule

// ==== hdl/tlb_unit.sv ====
module tlb_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  csr_pkg::tlb_op_t                tlb_op,

    // current tlb related csr values
    input  logic [csr_pkg::TLB_IDX_WID-1:0] tlbidx_index,
    input  logic [csr_pkg::VPPN_WID-1:0]    tlbehi_vppn,
    input  logic [31:0]                     tlbelo0,
    input  logic [31:0]                     tlbelo1,
    input  logic [csr_pkg::ASID_WID-1:0]    asid,

    // write request toward the csr file
    output logic                            tlb_we,
    output logic                            tlb_idx_ne,
    output logic [csr_pkg::TLB_IDX_WID-1:0] tlb_idx_index,
    output logic [csr_pkg::VPPN_WID-1:0]    tlb_ehi_vppn,
    output logic [31:0]                     tlb_elo0,
    output logic [31:0]                     tlb_elo1,
    output logic [csr_pkg::ASID_WID-1:0]    tlb_asid
);

    import csr_pkg::*;

    logic [VPPN_WID-1:0]    ent_vppn [TLB_NUM];
    logic [ASID_WID-1:0]    ent_asid [TLB_NUM];
    logic                   ent_g    [TLB_NUM];
    logic                   ent_e    [TLB_NUM];
    logic [31:0]            ent_elo0 [TLB_NUM];
    logic [31:0]            ent_elo1 [TLB_NUM];

    logic                   hit;
    logic [TLB_IDX_WID-1:0] hit_idx;

    // entry valid bits clear on reset and set on a tlb write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                ent_e[i] <= 1'b0;
            end
        end else if (tlb_op == tlb_wr) begin
            ent_e[tlbidx_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_op == tlb_wr) begin
            ent_vppn[tlbidx_index] <= tlbehi_vppn;
            ent_asid[tlbidx_index] <= asid;
            // global only when both halves are global
            ent_g[tlbidx_index]    <= tlbelo0[6] & tlbelo1[6];
            ent_elo0[tlbidx_index] <= tlbelo0;
            ent_elo1[tlbidx_index] <= tlbelo1;
        end
    end

    // fully associative compare of vppn plus asid unless the entry is global
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (ent_e[i] && ent_vppn[i] == tlbehi_vppn && (ent_g[i] || ent_asid[i] == asid)) begin
                hit     = 1'b1;
                hit_idx = TLB_IDX_WID'(i);
            end
        end
    end

    assign tlb_we = (tlb_op == tlb_srch) || (tlb_op == tlb_rd);

    // fields not touched by the op pass the current csr value back unchanged
    always_comb begin
        tlb_idx_ne    = 1'b1;
        tlb_idx_index = tlbidx_index;
        tlb_ehi_vppn  = tlbehi_vppn;
        tlb_elo0      = tlbelo0;
        tlb_elo1      = tlbelo1;
        tlb_asid      = asid;
        case (tlb_op)
            tlb_srch: begin
                tlb_idx_ne = !hit;
                if (hit) begin
                    tlb_idx_index = hit_idx;
                end
            end
            tlb_rd: begin
                if (ent_e[tlbidx_index]) begin
                    tlb_idx_ne   = 1'b0;
                    tlb_ehi_vppn = ent_vppn[tlbidx_index];
                    tlb_elo0     = ent_elo0[tlbidx_index];
                    tlb_elo1     = ent_elo1[tlbidx_index];
                    tlb_asid     = ent_asid[tlbidx_index];
                end else begin
                    tlb_ehi_vppn = '0;
                    tlb_elo0     = '0;
                    tlb_elo1     = '0;
                    tlb_asid     = '0;
                end
            end
            default: ;
        endcase
    end

    a_op_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(tlb_op))
        else $error("tlb_unit: tlb_op is unknown");

endmodule

// ==== hdl/csr_file.sv ====
module csr_file (
    input  logic                            clk,
    input  logic                            rst_n,

    // csr instruction port
    input  csr_pkg::csr_addr_t              csr_addr,
    input  logic                            csr_we,
    input  logic [31:0]                     csr_wdata,
    output logic [31:0]                     csr_rdata,

    // exception request
    input  logic                            excp_we,
    input  logic [1:0]                      new_prmd_pplv,
    input  logic                            new_prmd_pie,
    input  csr_pkg::ecode_t                 new_ecode,
    input  logic [31:0]                     new_era,
    input  logic                            badv_we,
    input  logic [31:0]                     new_badv,

    // tlb request
    input  logic                            tlb_we,
    input  logic                            tlb_idx_ne,
    input  logic [csr_pkg::TLB_IDX_WID-1:0] tlb_idx_index,
    input  logic [csr_pkg::VPPN_WID-1:0]    tlb_ehi_vppn,
    input  logic [31:0]                     tlb_elo0,
    input  logic [31:0]                     tlb_elo1,
    input  logic [csr_pkg::ASID_WID-1:0]    tlb_asid,

    input  logic                            ertn,

    // register values for the side units
    output logic [1:0]                      crmd_plv,
    output logic                            crmd_ie,
    output logic [31:0]                     eentry,
    output logic [31:0]                     era,
    output logic [csr_pkg::TLB_IDX_WID-1:0] tlbidx_index,
    output logic [csr_pkg::VPPN_WID-1:0]    tlbehi_vppn,
    output logic [31:0]                     tlbelo0,
    output logic [31:0]                     tlbelo1,
    output logic [csr_pkg::ASID_WID-1:0]    asid
);

    import csr_pkg::*;

    // only writable fields are stored and reserved bits read as zero
    logic [8:0]             crmd_q;
    logic [2:0]             prmd_q;
    logic [1:0]             estat_is;
    ecode_t                 estat_ecode;
    logic                   tlbidx_ne;
    logic [TLB_IDX_WID-1:0] tlbidx_idx;

    logic [31:0]            era_q;
    logic [31:0]            badv_q;
    logic [25:0]            eentry_q;
    logic [VPPN_WID-1:0]    tlbehi_q;
    // elo keeps ppn at 27:8 and the flag bits at 6:0
    logic [26:0]            elo0_q;
    logic [26:0]            elo1_q;
    logic [ASID_WID-1:0]    asid_q;
    logic [31:0]            save_q [4];

    // mode, privilege and index state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd_q      <= CRMD_RESET;
            prmd_q      <= '0;
            estat_is    <= '0;
            estat_ecode <= ecode_int;
            tlbidx_ne   <= 1'b1;
            tlbidx_idx  <= '0;
        end else if (excp_we) begin
            // entry drops to plv 0 with interrupts off
            crmd_q[2:0] <= 3'b000;
            prmd_q      <= {new_prmd_pie, new_prmd_pplv};
            estat_ecode <= new_ecode;
        end else if (tlb_we) begin
            tlbidx_ne  <= tlb_idx_ne;
            tlbidx_idx <= tlb_idx_index;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_CRMD:   crmd_q   <= csr_wdata[8:0];
                CSR_PRMD:   prmd_q   <= csr_wdata[2:0];
                // ecode is read-only to software
                CSR_ESTAT:  estat_is <= csr_wdata[1:0];
                CSR_TLBIDX: begin
                    tlbidx_ne  <= csr_wdata[31];
                    tlbidx_idx <= csr_wdata[TLB_IDX_WID-1:0];
                end
                default: ;
            endcase
        end else if (ertn) begin
            // prmd layout {pie, pplv} lines up with crmd {ie, plv}
            crmd_q[2:0] <= prmd_q;
        end
    end

    // address and translation data
    always_ff @(posedge clk) begin
        if (excp_we) begin
            era_q <= new_era;
            if (badv_we) begin
                badv_q <= new_badv;
            end
        end else if (tlb_we) begin
            tlbehi_q <= tlb_ehi_vppn;
            elo0_q   <= {tlb_elo0[27:8], tlb_elo0[6:0]};
            elo1_q   <= {tlb_elo1[27:8], tlb_elo1[6:0]};
            asid_q   <= tlb_asid;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_ERA:     era_q     <= csr_wdata;
                CSR_BADV:    badv_q    <= csr_wdata;
                CSR_EENTRY:  eentry_q  <= csr_wdata[31:6];
                CSR_TLBEHI:  tlbehi_q  <= csr_wdata[31:13];
                CSR_TLBELO0: elo0_q    <= {csr_wdata[27:8], csr_wdata[6:0]};
                CSR_TLBELO1: elo1_q    <= {csr_wdata[27:8], csr_wdata[6:0]};
                CSR_ASID:    asid_q    <= csr_wdata[ASID_WID-1:0];
                CSR_SAVE0:   save_q[0] <= csr_wdata;
                CSR_SAVE1:   save_q[1] <= csr_wdata;
                CSR_SAVE2:   save_q[2] <= csr_wdata;
                CSR_SAVE3:   save_q[3] <= csr_wdata;
                default: ;
            endcase
        end
    end

    assign crmd_plv     = crmd_q[1:0];
    assign crmd_ie      = crmd_q[2];
    assign eentry       = {eentry_q, 6'b0};
    assign era          = era_q;
    assign tlbidx_index = tlbidx_idx;
    assign tlbehi_vppn  = tlbehi_q;
    assign tlbelo0      = {4'b0, elo0_q[26:7], 1'b0, elo0_q[6:0]};
    assign tlbelo1      = {4'b0, elo1_q[26:7], 1'b0, elo1_q[6:0]};
    assign asid         = asid_q;

    always_comb begin
        case (csr_addr)
            CSR_CRMD:    csr_rdata = {23'b0, crmd_q};
            CSR_PRMD:    csr_rdata = {29'b0, prmd_q};
            CSR_ESTAT:   csr_rdata = {10'b0, estat_ecode, 14'b0, estat_is};
            CSR_ERA:     csr_rdata = era_q;
            CSR_BADV:    csr_rdata = badv_q;
            CSR_EENTRY:  csr_rdata = eentry;
            CSR_TLBIDX:  csr_rdata = {tlbidx_ne, {(31 - TLB_IDX_WID){1'b0}}, tlbidx_idx};
            CSR_TLBEHI:  csr_rdata = {tlbehi_q, 13'b0};
            CSR_TLBELO0: csr_rdata = tlbelo0;
            CSR_TLBELO1: csr_rdata = tlbelo1;
            // asidbits at 23:16 report the implemented asid width
            CSR_ASID:    csr_rdata = {8'b0, 8'(ASID_WID), {(16 - ASID_WID){1'b0}}, asid_q};
            CSR_SAVE0:   csr_rdata = save_q[0];
            CSR_SAVE1:   csr_rdata = save_q[1];
            CSR_SAVE2:   csr_rdata = save_q[2];
            CSR_SAVE3:   csr_rdata = save_q[3];
            default:     csr_rdata = '0;
        endcase
    end

    // tlb, instruction and ertn writes come from exclusive pipeline slots
    a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
        !excp_we |-> $onehot0({tlb_we, csr_we, ertn}))
        else $error("csr_file: more than one non-exception write source active");

endmodule

// ==== hdl/csr_subsystem.sv ====
module csr_subsystem (
    input  logic               clk,
    input  logic               rst_n,

    input  csr_pkg::csr_addr_t csr_addr,
    input  logic               csr_we,
    input  logic [31:0]        csr_wdata,
    output logic [31:0]        csr_rdata,

    input  logic               excp_valid,
    input  csr_pkg::ecode_t    excp_ecode,
    input  logic [31:0]        excp_pc,
    input  logic               excp_badv_valid,
    input  logic [31:0]        excp_badv,
    input  logic               ertn,

    input  csr_pkg::tlb_op_t   tlb_op,

    output logic               redirect_valid,
    output logic [31:0]        redirect_pc,
    output logic [1:0]         crmd_plv,
    output logic               crmd_ie
);

    import csr_pkg::*;

    // exception unit requests
    logic                   excp_we;
    logic [1:0]             new_prmd_pplv;
    logic                   new_prmd_pie;
    ecode_t                 new_ecode;
    logic [31:0]            new_era;
    logic                   badv_we;
    logic [31:0]            new_badv;

    // tlb unit requests
    logic                   tlb_we;
    logic                   tlb_idx_ne;
    logic [TLB_IDX_WID-1:0] tlb_idx_index;
    logic [VPPN_WID-1:0]    tlb_ehi_vppn;
    logic [31:0]            tlb_elo0;
    logic [31:0]            tlb_elo1;
    logic [ASID_WID-1:0]    tlb_asid;

    // register values fed back to the units
    logic [31:0]            eentry;
    logic [31:0]            era;
    logic [TLB_IDX_WID-1:0] tlbidx_index;
    logic [VPPN_WID-1:0]    tlbehi_vppn;
    logic [31:0]            tlbelo0;
    logic [31:0]            tlbelo1;
    logic [ASID_WID-1:0]    asid;

    excp_unit u_excp (
        .excp_valid, .excp_ecode, .excp_pc, .excp_badv_valid, .excp_badv, .ertn,
        .crmd_plv, .crmd_ie, .eentry, .era,
        .excp_we, .new_prmd_pplv, .new_prmd_pie, .new_ecode, .new_era, .badv_we, .new_badv,
        .redirect_valid, .redirect_pc
    );

    tlb_unit u_tlb (
        .clk, .rst_n, .tlb_op,
        .tlbidx_index, .tlbehi_vppn, .tlbelo0, .tlbelo1, .asid,
        .tlb_we, .tlb_idx_ne, .tlb_idx_index, .tlb_ehi_vppn, .tlb_elo0, .tlb_elo1, .tlb_asid
    );

    csr_file u_csr (
        .clk, .rst_n,
        .csr_addr, .csr_we, .csr_wdata, .csr_rdata,
        .excp_we, .new_prmd_pplv, .new_prmd_pie, .new_ecode, .new_era, .badv_we, .new_badv,
        .tlb_we, .tlb_idx_ne, .tlb_idx_index, .tlb_ehi_vppn, .tlb_elo0, .tlb_elo1, .tlb_asid,
        .ertn,
        .crmd_plv, .crmd_ie, .eentry, .era,
        .tlbidx_index, .tlbehi_vppn, .tlbelo0, .tlbelo1, .asid
    );

endmodule

// ==== test/csr_checker.sv ====
module csr_checker (
    input  logic         clk,
    input  logic         chk_valid,
    // 1 compares the redirect
    input  logic         chk_redirect,
    // 1 compares {crmd_ie, crmd_plv}, else csr_rdata
    input  logic         chk_mode,
    input  logic [127:0] chk_name,
    input  logic [31:0]  chk_exp,

    // observed DUT outputs
    input  logic [31:0]  csr_rdata,
    input  logic         redirect_valid,
    input  logic [31:0]  redirect_pc,
    input  logic [1:0]   crmd_plv,
    input  logic         crmd_ie,

    output int           pass_cnt,
    output int           fail_cnt
);

    int          n_pass = 0;
    int          n_fail = 0;
    logic [31:0] actual;

    assign pass_cnt = n_pass;
    assign fail_cnt = n_fail;

    // sample mid-cycle while the driven row is stable
    always @(negedge clk) begin
        if (chk_valid) begin
            if (chk_redirect) begin
                actual = redirect_pc;
            end else if (chk_mode) begin
                actual = {29'b0, crmd_ie, crmd_plv};
            end else begin
                actual = csr_rdata;
            end
            if (chk_redirect && redirect_valid !== 1'b1) begin
                $display("%0s: redirect_valid was not raised in the strobe cycle", chk_name);
                n_fail++;
            end else if (!chk_redirect && redirect_valid !== 1'b0) begin
                $display("%0s: redirect_valid was raised without an exception or ertn",
                         chk_name);
                n_fail++;
            end else if (actual !== chk_exp) begin
                $display("Mismatch %0s: expected %h, actual %h", chk_name, chk_exp, actual);
                n_fail++;
            end else begin
                $display("%0s: ok, %h", chk_name, actual);
                n_pass++;
            end
        end
    end

endmodule

// ==== test/tb_csr_subsystem.sv ====
module tb_csr_subsystem;

    import csr_pkg::*;

    typedef enum {s_wr, s_rd, s_mode, s_exc, s_exc_wr, s_ertn, s_tlb} step_kind_e;

    localparam int MAX_ROWS = 80;

    logic         clk = 1'b0;
    logic         rst_n;
    csr_addr_t    csr_addr;
    logic         csr_we;
    logic [31:0]  csr_wdata;
    logic [31:0]  csr_rdata;
    logic         excp_valid;
    ecode_t       excp_ecode;
    logic [31:0]  excp_pc;
    logic         excp_badv_valid;
    logic [31:0]  excp_badv;
    logic         ertn;
    tlb_op_t      tlb_op;
    logic         redirect_valid;
    logic [31:0]  redirect_pc;
    logic [1:0]   crmd_plv;
    logic         crmd_ie;

    // handoff to the checker
    logic         chk_valid;
    logic         chk_redirect;
    logic         chk_mode;
    logic [127:0] chk_name;
    logic [31:0]  chk_exp;
    int           pass_cnt;
    int           fail_cnt;

    // stimulus table, one row per step
    step_kind_e   row_kind  [MAX_ROWS];
    bit [127:0]   row_name  [MAX_ROWS];
    csr_addr_t    row_addr  [MAX_ROWS];
    logic [31:0]  row_data  [MAX_ROWS];
    logic [31:0]  row_exp   [MAX_ROWS];
    ecode_t       row_ecode [MAX_ROWS];
    logic [31:0]  row_pc    [MAX_ROWS];
    logic         row_bv    [MAX_ROWS];
    logic [31:0]  row_badv  [MAX_ROWS];

    int           n_rows   = 0;
    int           n_checks = 0;
    int           cycles   = 0;
    int           limit    = 0;
    logic [31:0]  save_val;

    csr_subsystem u_dut (
        .clk, .rst_n, .csr_addr, .csr_we, .csr_wdata, .csr_rdata,
        .excp_valid, .excp_ecode, .excp_pc, .excp_badv_valid, .excp_badv, .ertn,
        .tlb_op, .redirect_valid, .redirect_pc, .crmd_plv, .crmd_ie
    );

    csr_checker u_check (
        .clk, .chk_valid, .chk_redirect, .chk_mode, .chk_name, .chk_exp,
        .csr_rdata, .redirect_valid, .redirect_pc, .crmd_plv, .crmd_ie,
        .pass_cnt, .fail_cnt
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // kind s_tlb carries the tlb opcode in data
    task automatic append_row(input step_kind_e k, input bit [127:0] nm, input csr_addr_t a,
                              input logic [31:0] d, input logic [31:0] e);
        row_kind[n_rows]  = k;
        row_name[n_rows]  = nm;
        row_addr[n_rows]  = a;
        row_data[n_rows]  = d;
        row_exp[n_rows]   = e;
        row_ecode[n_rows] = ecode_int;
        row_pc[n_rows]    = '0;
        row_bv[n_rows]    = 1'b0;
        row_badv[n_rows]  = '0;
        if (k != s_wr && k != s_tlb) begin
            n_checks++;
        end
        n_rows++;
    endtask

    task automatic exception_row(input bit [127:0] nm, input ecode_t ec, input logic [31:0] pc,
                                 input logic bv, input logic [31:0] bd, input logic [31:0] e);
        append_row(s_exc, nm, '0, '0, e);
        row_ecode[n_rows-1] = ec;
        row_pc[n_rows-1]    = pc;
        row_bv[n_rows-1]    = bv;
        row_badv[n_rows-1]  = bd;
    endtask

    initial begin
        rst_n           <= 1'b0;
        csr_addr        <= '0;
        csr_we          <= 1'b0;
        csr_wdata       <= '0;
        excp_valid      <= 1'b0;
        excp_ecode      <= ecode_int;
        excp_pc         <= '0;
        excp_badv_valid <= 1'b0;
        excp_badv       <= '0;
        ertn            <= 1'b0;
        tlb_op          <= tlb_none;
        chk_valid       <= 1'b0;
        chk_redirect    <= 1'b0;
        chk_mode        <= 1'b0;
        chk_name        <= '0;
        chk_exp         <= '0;
        void'($urandom(32'hfcd70888));

        // writable masks and reserved-zero bits
        append_row(s_wr, "crmd_wr",     CSR_CRMD,    32'hffffffff, '0);
        append_row(s_rd, "crmd_mask",   CSR_CRMD,    '0, 32'h000001ff);
        // mode rows expect the output ports as {ie, plv}
        append_row(s_mode, "crmd_ports", '0,         '0, 32'h00000007);
        append_row(s_wr, "eentry_wr",   CSR_EENTRY,  32'hffffffff, '0);
        append_row(s_rd, "eentry_mask", CSR_EENTRY,  '0, 32'hffffffc0);
        append_row(s_wr, "tlbehi_wr",   CSR_TLBEHI,  32'hffffffff, '0);
        append_row(s_rd, "tlbehi_mask", CSR_TLBEHI,  '0, 32'hffffe000);
        append_row(s_wr, "asid_wr",     CSR_ASID,    32'hffffffff, '0);
        // asidbits at 23:16 hold 10
        append_row(s_rd, "asid_mask",   CSR_ASID,    '0, 32'h000a03ff);
        for (int i = 0; i < 4; i++) begin
            save_val = $urandom();
            append_row(s_wr, "save_wr", csr_addr_t'(CSR_SAVE0 + i), save_val, '0);
            append_row(s_rd, 128'({"save", 8'h30 + 8'(i)}), csr_addr_t'(CSR_SAVE0 + i),
                       '0, save_val);
        end
        append_row(s_rd, "unmapped",    14'h002,     '0, 32'h0);

        // exception entry from plv 3 with ie set
        append_row(s_wr, "eentry_set",  CSR_EENTRY,  32'h1c000100, '0);
        append_row(s_wr, "crmd_set",    CSR_CRMD,    32'h0000000f, '0);
        exception_row("excp_ade", ecode_ade, 32'h1c001234, 1'b1, 32'hdeadbeef, 32'h1c000100);
        append_row(s_rd, "excp_crmd",   CSR_CRMD,    '0, 32'h00000008);
        append_row(s_mode, "excp_ports", '0,         '0, 32'h00000000);
        append_row(s_rd, "excp_prmd",   CSR_PRMD,    '0, 32'h00000007);
        append_row(s_rd, "excp_estat",  CSR_ESTAT,   '0, 32'h00080000);
        append_row(s_rd, "excp_era",    CSR_ERA,     '0, 32'h1c001234);
        append_row(s_rd, "excp_badv",   CSR_BADV,    '0, 32'hdeadbeef);
        // without badv_valid the old address stays in badv
        exception_row("excp_sys", ecode_sys, 32'h1c002000, 1'b0, 32'h12345678, 32'h1c000100);
        append_row(s_rd, "sys_badv",    CSR_BADV,    '0, 32'hdeadbeef);
        append_row(s_rd, "sys_estat",   CSR_ESTAT,   '0, 32'h000b0000);

        // return to plv 2 with ie set
        append_row(s_wr, "prmd_set",    CSR_PRMD,    32'h00000006, '0);
        append_row(s_ertn, "ertn",      '0,          '0, 32'h1c002000);
        append_row(s_rd, "ertn_crmd",   CSR_CRMD,    '0, 32'h0000000e);
        append_row(s_mode, "ertn_ports", '0,         '0, 32'h00000006);

        // entry 2 with g only in elo0 so the asid has to match
        append_row(s_wr, "tlbidx_set",  CSR_TLBIDX,  32'h00000002, '0);
        append_row(s_wr, "tlbehi_set",  CSR_TLBEHI,  32'h12346000, '0);
        append_row(s_wr, "elo0_set",    CSR_TLBELO0, 32'hf12345d3, '0);
        append_row(s_wr, "elo1_set",    CSR_TLBELO1, 32'h00abcd9f, '0);
        append_row(s_wr, "asid_set",    CSR_ASID,    32'h00000155, '0);
        append_row(s_tlb, "tlbwr",      '0,          32'(tlb_wr), '0);
        append_row(s_wr, "tlbidx_clr",  CSR_TLBIDX,  32'h80000001, '0);
        append_row(s_tlb, "srch",       '0,          32'(tlb_srch), '0);
        append_row(s_rd, "srch_hit",    CSR_TLBIDX,  '0, 32'h00000002);
        append_row(s_wr, "tlbehi_miss", CSR_TLBEHI,  32'h0aaaa000, '0);
        append_row(s_tlb, "srch",       '0,          32'(tlb_srch), '0);
        append_row(s_rd, "srch_miss",   CSR_TLBIDX,  '0, 32'h80000002);

        // read entry 2 back over cleared registers
        append_row(s_wr, "elo0_clr",    CSR_TLBELO0, 32'h0, '0);
        append_row(s_wr, "elo1_clr",    CSR_TLBELO1, 32'h0, '0);
        append_row(s_wr, "asid_clr",    CSR_ASID,    32'h0, '0);
        append_row(s_tlb, "rd_idx2",    '0,          32'(tlb_rd), '0);
        append_row(s_rd, "rd_tlbehi",   CSR_TLBEHI,  '0, 32'h12346000);
        append_row(s_rd, "rd_elo0",     CSR_TLBELO0, '0, 32'h01234553);
        append_row(s_rd, "rd_elo1",     CSR_TLBELO1, '0, 32'h00abcd1f);
        append_row(s_rd, "rd_asid",     CSR_ASID,    '0, 32'h000a0155);
        append_row(s_rd, "rd_tlbidx",   CSR_TLBIDX,  '0, 32'h00000002);

        // entry 1 was never written
        append_row(s_wr, "tlbidx_one",  CSR_TLBIDX,  32'h00000001, '0);
        append_row(s_tlb, "rd_idx1",    '0,          32'(tlb_rd), '0);
        append_row(s_rd, "inv_tlbidx",  CSR_TLBIDX,  '0, 32'h80000001);
        append_row(s_rd, "inv_tlbehi",  CSR_TLBEHI,  '0, 32'h0);
        append_row(s_rd, "inv_elo0",    CSR_TLBELO0, '0, 32'h0);
        append_row(s_rd, "inv_elo1",    CSR_TLBELO1, '0, 32'h0);
        append_row(s_rd, "inv_asid",    CSR_ASID,    '0, 32'h000a0000);

        // exception beats a same-cycle era write
        exception_row("prio_excp", ecode_brk, 32'h1c003000, 1'b0, '0, 32'h1c000100);
        row_kind[n_rows-1] = s_exc_wr;
        row_addr[n_rows-1] = CSR_ERA;
        row_data[n_rows-1] = 32'h11111111;
        append_row(s_rd, "prio_era",    CSR_ERA,     '0, 32'h1c003000);

        // two cycles per row, the reset, and some margin
        limit = n_rows * 2 + 10 + 20;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            csr_addr        <= row_addr[i];
            csr_we          <= (row_kind[i] == s_wr) || (row_kind[i] == s_exc_wr);
            csr_wdata       <= row_data[i];
            excp_valid      <= (row_kind[i] == s_exc) || (row_kind[i] == s_exc_wr);
            excp_ecode      <= row_ecode[i];
            excp_pc         <= row_pc[i];
            excp_badv_valid <= row_bv[i];
            excp_badv       <= row_badv[i];
            ertn            <= row_kind[i] == s_ertn;
            tlb_op          <= (row_kind[i] == s_tlb) ? tlb_op_t'(row_data[i][1:0]) : tlb_none;
            chk_valid       <= (row_kind[i] != s_wr) && (row_kind[i] != s_tlb);
            chk_redirect    <= (row_kind[i] == s_exc) || (row_kind[i] == s_exc_wr) ||
                               (row_kind[i] == s_ertn);
            chk_mode        <= row_kind[i] == s_mode;
            chk_name        <= row_name[i];
            chk_exp         <= row_exp[i];
            @(posedge clk);
            csr_we     <= 1'b0;
            excp_valid <= 1'b0;
            ertn       <= 1'b0;
            tlb_op     <= tlb_none;
            chk_valid  <= 1'b0;
        end
        @(posedge clk);

        if (pass_cnt + fail_cnt != n_checks) begin
            $display("Error: only %0d of %0d checks ran", pass_cnt + fail_cnt, n_checks);
        end
        $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == n_checks) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/csr_pkg.sv
hdl/excp_unit.sv
hdl/tlb_unit.sv
hdl/csr_file.sv
hdl/csr_subsystem.sv
test/csr_checker.sv
test/tb_csr_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_csr_subsystem
FILELIST  := tb.f
FLAGS     := --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
